// File: hdl/crg_pkg.sv
// --------------------
// shared constants and types for the CRG control block
// import into any module that decodes the APB map or the domains
// --------------------
package crg_pkg;

  // -------------------- widths
  localparam int NUM_DOMAINS = 5;          // cpu, axi, apb, i2c, imp
  localparam int DIV_W       = 4;          // divisor nibble per domain
  localparam int CNT_W       = 16;         // pulse counter, wraps
  localparam int APB_ADDR_W  = 12;
  localparam int APB_DATA_W  = 32;

  // -------------------- address map
  localparam logic [APB_ADDR_W-1:0] ADDR_DIV       = 12'h000;  // domain d at bits 4d+3..4d
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL      = 12'h004;  // tog and cken
  localparam logic [APB_ADDR_W-1:0] ADDR_STAT_BASE = 12'h100;  // counter d at base + 4d
  localparam logic [APB_ADDR_W-1:0] ADDR_STAT_LAST =
    ADDR_STAT_BASE + APB_ADDR_W'(4 * (NUM_DOMAINS - 1));       // last counter word

  // ctrl register field positions
  localparam int CTRL_TOG_LSB  = 0;        // write one, reads 0
  localparam int CTRL_CKEN_LSB = 8;        // enable bits, reset to on

  // bit index of each domain in every per-domain vector
  typedef enum logic [2:0] {
    DOM_CPU = 3'd0,
    DOM_AXI = 3'd1,
    DOM_APB = 3'd2,
    DOM_I2C = 3'd3,
    DOM_IMP = 3'd4
  } domain_e;

  // decoded target of one apb access
  typedef enum logic [1:0] {
    SEL_REGS = 2'd0,                       // div / ctrl registers
    SEL_STAT = 2'd1,                       // pulse counters
    SEL_NONE = 2'd2                        // unmapped, slave error
  } apb_sel_e;

endpackage

// File: hdl/apb_slave_mux.sv
// --------------------
// APB address decode for the two CRG slaves
// forwards psel to one slave, returns its read data or a slave error
// --------------------
`timescale 1ns/10ps

module apb_slave_mux (
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic [crg_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  logic [crg_pkg::APB_DATA_W-1:0]  regs_rdata_i,   // slave 0 read data
  input  logic [crg_pkg::APB_DATA_W-1:0]  stat_rdata_i,   // slave 1 read data
  output logic                            regs_psel_o,
  output logic                            stat_psel_o,
  output logic [crg_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                            pslverr_o
);

  import crg_pkg::*;

  apb_sel_e sel;                                          // decoded target

  // -------------------- decode
  always_comb begin
    if (paddr_i == ADDR_DIV || paddr_i == ADDR_CTRL) begin
      sel = SEL_REGS;
    end else if (paddr_i[1:0] == 2'b00 &&                 // word aligned only
                 paddr_i >= ADDR_STAT_BASE &&
                 paddr_i <= ADDR_STAT_LAST) begin         // no counter past imp
      sel = SEL_STAT;
    end else begin
      sel = SEL_NONE;
    end
  end

  assign regs_psel_o = psel_i && (sel == SEL_REGS);
  assign stat_psel_o = psel_i && (sel == SEL_STAT);

  // -------------------- response
  always_comb begin
    case (sel)
      SEL_REGS: prdata_o = regs_rdata_i;
      SEL_STAT: prdata_o = stat_rdata_i;
      default:  prdata_o = '0;                            // unmapped reads 0
    endcase
  end

  // error flagged in the access cycle only
  assign pslverr_o = psel_i && penable_i && (sel == SEL_NONE);

endmodule

// File: hdl/crg_apb_regs.sv
// --------------------
// divisor and control registers, APB slave 0 of the CRG block
// a divisor is staged in DIV and applied per domain by the CTRL tog bits
// --------------------
`timescale 1ns/10ps

module crg_apb_regs (
  input  logic                                               clk,
  input  logic                                               reset_i,
  input  logic                                               psel_i,
  input  logic                                               penable_i,
  input  logic                                               pwrite_i,
  input  logic [crg_pkg::APB_ADDR_W-1:0]                     paddr_i,
  input  logic [crg_pkg::APB_DATA_W-1:0]                     pwdata_i,
  output logic [crg_pkg::APB_DATA_W-1:0]                     prdata_o,
  output logic [crg_pkg::NUM_DOMAINS-1:0][crg_pkg::DIV_W-1:0] active_div_o,
  output logic [crg_pkg::NUM_DOMAINS-1:0]                    cken_o,
  output logic [crg_pkg::NUM_DOMAINS-1:0]                    tog_o
);

  import crg_pkg::*;

  logic [NUM_DOMAINS-1:0][DIV_W-1:0] pending_div;         // written, not yet applied
  logic [NUM_DOMAINS-1:0][DIV_W-1:0] active_div;          // in use by the bank
  logic [NUM_DOMAINS-1:0]            cken;                // per domain enable
  logic                              wr_en;               // write access cycle
  logic                              ctrl_sel;            // 1 = ctrl, 0 = div
  logic [APB_DATA_W-1:0]             rdata;

  // -------------------- access decode
  assign wr_en    = psel_i && penable_i && pwrite_i;
  assign ctrl_sel = paddr_i[2];                           // only 0x000 and 0x004 reach here

  // apply strobe, one cycle wide
  assign tog_o = (wr_en && ctrl_sel) ? pwdata_i[CTRL_TOG_LSB +: NUM_DOMAINS]
                                     : '0;

  // -------------------- registers
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pending_div <= '0;
      active_div  <= '0;
      cken        <= '1;                                  // clocks run out of reset
    end else if (wr_en) begin
      if (ctrl_sel) begin
        cken <= pwdata_i[CTRL_CKEN_LSB +: NUM_DOMAINS];
        for (int d = 0; d < NUM_DOMAINS; d++) begin
          if (tog_o[d]) begin
            active_div[d] <= pending_div[d];              // apply staged divisor
          end
        end
      end else begin
        pending_div <= pwdata_i[NUM_DOMAINS*DIV_W-1:0];   // staged only
      end
    end
  end

  // -------------------- read back
  always_comb begin
    rdata = '0;
    if (ctrl_sel) begin
      rdata[CTRL_CKEN_LSB +: NUM_DOMAINS] = cken;         // tog field reads 0
    end else begin
      rdata[NUM_DOMAINS*DIV_W-1:0] = pending_div;
    end
  end

  assign prdata_o     = psel_i ? rdata : '0;
  assign active_div_o = active_div;
  assign cken_o       = cken;

endmodule

// File: hdl/clk_en_bank.sv
// --------------------
// per domain clock enable dividers and pulse counters, APB slave 1
// domain d pulses once every D+1 cycles while its cken bit is set
// --------------------
`timescale 1ns/10ps

module clk_en_bank (
  input  logic                                               clk,
  input  logic                                               reset_i,
  input  logic                                               psel_i,
  input  logic [crg_pkg::APB_ADDR_W-1:0]                     paddr_i,
  input  logic [crg_pkg::NUM_DOMAINS-1:0][crg_pkg::DIV_W-1:0] active_div_i,
  input  logic [crg_pkg::NUM_DOMAINS-1:0]                    cken_i,
  input  logic [crg_pkg::NUM_DOMAINS-1:0]                    tog_i,
  output logic [crg_pkg::APB_DATA_W-1:0]                     prdata_o,
  output logic [crg_pkg::NUM_DOMAINS-1:0]                    clk_en_o
);

  import crg_pkg::*;

  logic [CNT_W-1:0] pulse_cnt [NUM_DOMAINS];              // counters seen by the read mux
  logic [2:0]       rd_idx;                               // counter word index

  // -------------------- domains
  for (genvar g = int'(DOM_CPU); g <= int'(DOM_IMP); g++) begin : g_dom
    logic [DIV_W-1:0] div_cnt;                            // phase within the period
    logic [CNT_W-1:0] cnt;                                // pulses since last tog
    logic             pulse;

    // last phase of the period, held low while disabled
    assign pulse = cken_i[g] && (div_cnt == active_div_i[g]);

    always_ff @(posedge clk) begin
      if (reset_i) begin
        div_cnt <= '0;
        cnt     <= '0;
      end else if (tog_i[g]) begin
        div_cnt <= '0;                                    // restart on apply
        cnt     <= '0;
      end else if (cken_i[g]) begin
        div_cnt <= pulse ? '0 : div_cnt + 1'b1;           // wrap at D
        if (pulse) begin
          cnt <= cnt + 1'b1;                              // wraps at 16 bits
        end
      end
    end

    assign clk_en_o[g]  = pulse;
    assign pulse_cnt[g] = cnt;
  end

  // -------------------- read back
  assign rd_idx = paddr_i[4:2];                           // 0x100 + 4d

  always_comb begin
    prdata_o = '0;
    if (psel_i && rd_idx < NUM_DOMAINS) begin
      prdata_o[CNT_W-1:0] = pulse_cnt[rd_idx];            // zero extended
    end
  end

endmodule

// File: hdl/crg_top.sv
// --------------------
// CRG control top level, one APB port and one enable pulse per domain
// wires the address mux, the register slave and the enable bank
// --------------------
`timescale 1ns/10ps

module crg_top (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [crg_pkg::APB_ADDR_W-1:0]   paddr_i,
  input  logic [crg_pkg::APB_DATA_W-1:0]   pwdata_i,
  output logic [crg_pkg::APB_DATA_W-1:0]   prdata_o,
  output logic                             pslverr_o,
  output logic [crg_pkg::NUM_DOMAINS-1:0]  clk_en_o
);

  import crg_pkg::*;

  logic                              regs_psel;           // slave 0 select
  logic                              stat_psel;           // slave 1 select
  logic [APB_DATA_W-1:0]             regs_rdata;
  logic [APB_DATA_W-1:0]             stat_rdata;
  logic [NUM_DOMAINS-1:0][DIV_W-1:0] active_div;          // applied divisors
  logic [NUM_DOMAINS-1:0]            cken;
  logic [NUM_DOMAINS-1:0]            tog;                 // apply strobe

  // -------------------- apb decode
  apb_slave_mux u0_apb_slave_mux (
    .psel_i        ( psel_i     ),
    .penable_i     ( penable_i  ),
    .paddr_i       ( paddr_i    ),
    .regs_rdata_i  ( regs_rdata ),
    .stat_rdata_i  ( stat_rdata ),
    .regs_psel_o   ( regs_psel  ),
    .stat_psel_o   ( stat_psel  ),
    .prdata_o      ( prdata_o   ),
    .pslverr_o     ( pslverr_o  )
  );

  // -------------------- slave 0
  crg_apb_regs u0_crg_apb_regs (
    .clk           ( clk        ),
    .reset_i       ( reset_i    ),
    .psel_i        ( regs_psel  ),
    .penable_i     ( penable_i  ),
    .pwrite_i      ( pwrite_i   ),
    .paddr_i       ( paddr_i    ),
    .pwdata_i      ( pwdata_i   ),
    .prdata_o      ( regs_rdata ),
    .active_div_o  ( active_div ),
    .cken_o        ( cken       ),
    .tog_o         ( tog        )
  );

  // -------------------- slave 1
  clk_en_bank u0_clk_en_bank (
    .clk           ( clk        ),
    .reset_i       ( reset_i    ),
    .psel_i        ( stat_psel  ),
    .paddr_i       ( paddr_i    ),
    .active_div_i  ( active_div ),
    .cken_i        ( cken       ),
    .tog_i         ( tog        ),
    .prdata_o      ( stat_rdata ),
    .clk_en_o      ( clk_en_o   )
  );

endmodule

// File: sim/crg_tb.sv
// --------------------
// table driven testbench for the CRG control block
// runs APB transfers from a table while a monitor predicts every enable pulse
// --------------------
`timescale 1ns/10ps

module crg_tb;

  import crg_pkg::*;

  localparam int          HALF   = 10;                    // 20 ns clock
  localparam int          RST_CY = 5;
  localparam int          MARGIN = 100;
  localparam int unsigned SEED   = 32'hc28f1ade;

  typedef struct {
    string                 name;
    logic [APB_ADDR_W-1:0] addr;
    bit                    wr;
    logic [APB_DATA_W-1:0] wdata;
    logic [APB_DATA_W-1:0] exp_rdata;
    bit                    exp_err;
    int                    wait_cyc;                      // idle cycles after the transfer
    bit                    from_mon;                      // expected count comes from the monitor
  } entry_t;

  logic                   clk;
  logic                   reset_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [APB_ADDR_W-1:0]  paddr_i;
  logic [APB_DATA_W-1:0]  pwdata_i;
  logic [APB_DATA_W-1:0]  prdata_o;
  logic                   pslverr_o;
  logic [NUM_DOMAINS-1:0] clk_en_o;

  entry_t                 tbl[$];
  string                  cur_name = "reset";
  int                     errors = 0;
  int                     checks = 0;
  int                     cycles = 0;
  int                     cycle_limit = 0;

  // reference model of the divider bank
  logic [DIV_W-1:0]       pend_m [NUM_DOMAINS];
  logic [DIV_W-1:0]       act_m  [NUM_DOMAINS];
  logic [NUM_DOMAINS-1:0] cken_m;
  int                     k_m    [NUM_DOMAINS];           // enabled cycles since apply
  logic [CNT_W-1:0]       cnt_m  [NUM_DOMAINS];

  crg_top DUT (
    .clk       ( clk       ),
    .reset_i   ( reset_i   ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .prdata_o  ( prdata_o  ),
    .pslverr_o ( pslverr_o ),
    .clk_en_o  ( clk_en_o  )
  );

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  // -------------------- helpers
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic add_entry(input string name, input logic [APB_ADDR_W-1:0] addr,
                           input bit wr, input logic [31:0] wdata, input logic [31:0] exp,
                           input bit err, input int wait_cyc, input bit from_mon);
    entry_t e;
    e = '{name, addr, wr, wdata, exp, err, wait_cyc, from_mon};
    tbl.push_back(e);
  endtask

  task automatic add_cnt_reads(input string tag);
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      add_entry($sformatf("%s_cnt%0d", tag, d), ADDR_STAT_BASE + 12'(4 * d), 1'b0, '0, '0,
                1'b0, 0, 1'b1);
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd_div;
    logic [4:0]  rnd_tog;
    add_entry("rst_div",  ADDR_DIV,  1'b0, '0, 32'h0,    1'b0, 2, 1'b0);
    add_entry("rst_ctrl", ADDR_CTRL, 1'b0, '0, 32'h1F00, 1'b0, 0, 1'b0);
    add_cnt_reads("rst");
    // staged only and upper bits dropped
    add_entry("pend_wr",  ADDR_DIV,  1'b1, 32'hFFF4_3210, '0,   1'b0, 6, 1'b0);
    add_entry("pend_rd",  ADDR_DIV,  1'b0, '0, 32'h0004_3210,   1'b0, 0, 1'b0);
    add_entry("tog_part", ADDR_CTRL, 1'b1, 32'h0000_1F0A, '0,   1'b0, 20, 1'b0);  // axi, i2c
    add_entry("tog_all",  ADDR_CTRL, 1'b1, 32'h0000_1F1F, '0,   1'b0, 30, 1'b0);
    add_entry("ctrl_rd",  ADDR_CTRL, 1'b0, '0, 32'h1F00,        1'b0, 0, 1'b0);
    // -------------------- unmapped
    add_entry("err_008",  12'h008, 1'b0, '0, 32'h0, 1'b1, 0, 1'b0);
    add_entry("err_0fc",  12'h0FC, 1'b0, '0, 32'h0, 1'b1, 0, 1'b0);
    add_entry("err_114",  12'h114, 1'b0, '0, 32'h0, 1'b1, 0, 1'b0);
    add_entry("err_200",  12'h200, 1'b0, '0, 32'h0, 1'b1, 0, 1'b0);
    add_entry("err_102",  12'h102, 1'b0, '0, 32'h0, 1'b1, 0, 1'b0);
    add_entry("err_wr008", 12'h008, 1'b1, 32'hFFFF_FFFF, '0, 1'b1, 0, 1'b0);
    add_entry("err_wr102", 12'h102, 1'b1, 32'h0000_0000, '0, 1'b1, 2, 1'b0);
    add_entry("err_div",  ADDR_DIV,  1'b0, '0, 32'h0004_3210, 1'b0, 0, 1'b0);
    add_entry("err_ctrl", ADDR_CTRL, 1'b0, '0, 32'h1F00,      1'b0, 0, 1'b0);
    add_entry("stat_wr",  12'h104, 1'b1, 32'h0000_FFFF, '0, 1'b0, 1, 1'b0);  // ignored
    add_entry("stat_rd",  12'h104, 1'b0, '0, '0, 1'b0, 0, 1'b1);
    // -------------------- counters hold while cken is off
    add_entry("cken_off", ADDR_CTRL, 1'b1, 32'h0, '0, 1'b0, 10, 1'b0);
    add_cnt_reads("off");
    add_entry("off_cnt0b", ADDR_STAT_BASE, 1'b0, '0, '0, 1'b0, 0, 1'b1);  // second read
    add_entry("cken_part", ADDR_CTRL, 1'b1, 32'h0000_0500, '0, 1'b0, 15, 1'b0);  // cpu, apb
    add_entry("part_ctrl", ADDR_CTRL, 1'b0, '0, 32'h0500, 1'b0, 0, 1'b0);
    add_cnt_reads("part");
    add_entry("cken_on",  ADDR_CTRL, 1'b1, 32'h0000_1F00, '0, 1'b0, 10, 1'b0);
    // -------------------- random divisors
    for (int i = 0; i < 3; i++) begin
      rnd_div = $urandom() & 32'h000F_FFFF;               // five nibbles
      rnd_tog = 5'($urandom());
      add_entry($sformatf("rnd%0d_div", i), ADDR_DIV, 1'b1, rnd_div, '0, 1'b0, 0, 1'b0);
      add_entry($sformatf("rnd%0d_rd", i),  ADDR_DIV, 1'b0, '0, rnd_div, 1'b0, 0, 1'b0);
      add_entry($sformatf("rnd%0d_tog", i), ADDR_CTRL, 1'b1, {19'h0, 5'h1F, 3'h0, rnd_tog},
                '0, 1'b0, 40, 1'b0);
      add_cnt_reads($sformatf("rnd%0d", i));
    end
  endtask

  // one transfer that starts and ends on a falling edge
  task automatic apb_xfer(input entry_t e);
    logic [31:0] rdata;
    logic        err;
    int          idx;
    psel_i    = 1'b1;                                     // setup cycle
    penable_i = 1'b0;
    pwrite_i  = e.wr;
    paddr_i   = e.addr;
    pwdata_i  = e.wdata;
    @(negedge clk);
    penable_i = 1'b1;                                     // access cycle
    #(HALF - 1);                                          // just before the rising edge
    rdata = prdata_o;
    err   = pslverr_o;
    check({e.name, " pslverr"}, 32'(e.exp_err), 32'(err));
    if (!e.wr) begin
      if (e.from_mon) begin
        idx = int'(e.addr - ADDR_STAT_BASE) / 4;
        check({e.name, " prdata"}, 32'(cnt_m[idx]), rdata);
      end else begin
        check({e.name, " prdata"}, e.exp_rdata, rdata);
      end
    end
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    repeat (e.wait_cyc) @(negedge clk);
  endtask

  // -------------------- pulse monitor
  initial begin
    logic [NUM_DOMAINS-1:0] exp_en;
    logic                   ctrl_wr;
    forever begin
      @(posedge clk);
      if (reset_i) begin
        cken_m = '1;                                      // clocks on out of reset
        for (int d = 0; d < NUM_DOMAINS; d++) begin
          pend_m[d] = '0;
          act_m[d]  = '0;
          k_m[d]    = 0;
          cnt_m[d]  = '0;
        end
      end else begin
        for (int d = 0; d < NUM_DOMAINS; d++) begin
          exp_en[d] = cken_m[d] && ((k_m[d] % (int'(act_m[d]) + 1)) == int'(act_m[d]));
        end
        check({cur_name, " clk_en"}, 32'(exp_en), 32'(clk_en_o));
        ctrl_wr = psel_i && penable_i && pwrite_i && (paddr_i == ADDR_CTRL);
        for (int d = 0; d < NUM_DOMAINS; d++) begin
          if (ctrl_wr && pwdata_i[d]) begin
            act_m[d] = pend_m[d];                         // apply restarts the phase
            k_m[d]   = 0;
            cnt_m[d] = '0;
          end else if (cken_m[d]) begin
            k_m[d]++;
            if (exp_en[d]) begin
              cnt_m[d] = cnt_m[d] + 1'b1;
            end
          end
        end
        if (ctrl_wr) begin
          cken_m = pwdata_i[12:8];
        end
        if (psel_i && penable_i && pwrite_i && (paddr_i == ADDR_DIV)) begin
          for (int d = 0; d < NUM_DOMAINS; d++) begin
            pend_m[d] = pwdata_i[4*d +: 4];
          end
        end
      end
    end
  end

  // -------------------- timeout
  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run timed out after %0d cycles without reaching the end of the table",
             cycle_limit);
    $display("TESTS FAILED");
    $finish;
  end

  // -------------------- main
  initial begin
    int total;
    void'($urandom(SEED));                                // seed once
    reset_i   = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    build_table();
    total = RST_CY + MARGIN;
    foreach (tbl[i]) begin
      total += 2 + tbl[i].wait_cyc;
    end
    cycle_limit = total;
    repeat (RST_CY) @(negedge clk);
    reset_i = 1'b0;
    foreach (tbl[i]) begin
      cur_name = tbl[i].name;
      apb_xfer(tbl[i]);
    end
    @(negedge clk);
    $display("checks %0d, errors %0d, seed %h", checks, errors, SEED);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
hdl/crg_pkg.sv
hdl/apb_slave_mux.sv
hdl/crg_apb_regs.sv
hdl/clk_en_bank.sv
hdl/crg_top.sv
sim/crg_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the CRG testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module crg_tb -f project.f -o crg_tb_sim

./obj_dir/crg_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
